/* bench/tb_lpif_tests.svh */
//////////////////////////////////////////////////
// Directed tests for the LPIF link
// Reset state, online delays, loopback data
// Strobe and marker, status counters, lane mismatch
//////////////////////////////////////////////////

`ifndef TB_LPIF_TESTS_SVH
`define TB_LPIF_TESTS_SVH

task automatic test_reset_state();
  int err_start;
  err_start = error_count;
  if (ustrm !== '0) report_mismatch("ustrm", '0, 160'(ustrm));
  if (tx_downstream_debug_status !== '0)
    report_mismatch("tx_downstream_debug_status", '0, 160'(tx_downstream_debug_status));
  if (rx_upstream_debug_status !== '0)
    report_mismatch("rx_upstream_debug_status", '0, 160'(rx_upstream_debug_status));
  // TX offline, lanes must stay quiet
  for (int i = 0; i < 4; i++) begin
    if (tx_phy !== '0) report_mismatch("tx_phy", '0, tx_phy);
    dstrm       = random_word();
    dstrm.valid = 1'b1;
    @(negedge clk_wr);
  end
  finish_test("reset_state", err_start);
endtask

task automatic test_online_delay();
  int err_start;
  int edges;
  int exp_edges;
  err_start      = error_count;
  delay_xz_value = 8'd5;
  delay_x_value  = 8'd3;
  delay_yz_value = 8'd4;
  dstrm          = random_word();
  dstrm.valid    = 1'b1;
  tx_online      = 1'b1;
  // Sampling edge and delay edges, then one more through the tx_phy register
  exp_edges = int'(delay_xz_value) + 2;
  wait_flag(0, 1'b1, 40, "tx_phy strobe", edges);
  if (edges != exp_edges) report_mismatch("tx strobe rise edge", 160'(exp_edges), 160'(edges));
  rx_online = 1'b1;
  // Same count on the receive side, through the ustrm register
  exp_edges = int'(delay_x_value) + int'(delay_yz_value) + 2;
  wait_flag(1, 1'b1, 40, "ustrm.valid", edges);
  if (edges != exp_edges) report_mismatch("ustrm rise edge", 160'(exp_edges), 160'(edges));
  finish_test("online_delay", err_start);
endtask

task automatic test_loopback();
  int           err_start;
  lpif_stream_t exp_q[$];
  lpif_stream_t word;
  lpif_stream_t exp_word;
  err_start = error_count;
  for (int i = 0; i < 52; i++) begin
    @(negedge clk_wr);
    // Word from two falling edges back
    if (i >= 2) begin
      exp_word = exp_q.pop_front();
      if (ustrm !== exp_word)
        report_mismatch($sformatf("ustrm word %0d", i - 2), 160'(exp_word), 160'(ustrm));
    end
    if (i < 50) begin
      word  = random_word();
      dstrm = word;
      exp_q.push_back(word);
    end else begin
      dstrm = '0;
    end
  end
  finish_test("loopback", err_start);
endtask

task automatic test_marker_strobe();
  int   err_start;
  int   edges;
  logic exp_mrk;
  err_start = error_count;
  tx_online = 1'b0;
  wait_flag(0, 1'b0, 10, "tx_phy strobe", edges);
  delay_xz_value = 8'd2;
  tx_online      = 1'b1;
  wait_flag(0, 1'b1, 20, "tx_phy strobe", edges);
  exp_mrk = 1'b1;
  for (int c = 0; c < 12; c++) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (tx_phy[l][STB_BIT] !== 1'b1)
        report_mismatch($sformatf("tx_phy[%0d] strobe", l), 160'(1), 160'(tx_phy[l][STB_BIT]));
      if (tx_phy[l][MRK_BIT] !== exp_mrk)
        report_mismatch($sformatf("tx_phy[%0d] marker", l), 160'(exp_mrk),
                        160'(tx_phy[l][MRK_BIT]));
    end
    exp_mrk = ~exp_mrk;
    @(negedge clk_wr);
  end
  finish_test("marker_strobe", err_start);
endtask

task automatic test_status_counters();
  int           err_start;
  int           sent;
  lpif_stream_t word;
  logic [31:0]  tx_start;
  logic [31:0]  tx_delta;
  logic [15:0]  rx_start;
  logic [15:0]  rx_delta;
  err_start = error_count;
  dstrm     = '0;
  repeat (2) @(negedge clk_wr);
  tx_start = tx_downstream_debug_status;
  rx_start = rx_upstream_debug_status[15:0];
  sent     = 0;
  for (int i = 0; i < 20; i++) begin
    word  = random_word();
    dstrm = word;
    if (word.valid) sent++;
    @(negedge clk_wr);
  end
  dstrm = '0;
  repeat (2) @(negedge clk_wr);
  tx_delta = tx_downstream_debug_status - tx_start;
  rx_delta = rx_upstream_debug_status[15:0] - rx_start;
  if (tx_delta !== 32'(sent)) report_mismatch("tx status delta", 160'(sent), 160'(tx_delta));
  if (rx_delta !== 16'(sent)) report_mismatch("rx status delta", 160'(sent), 160'(rx_delta));
  finish_test("status_counters", err_start);
endtask

task automatic test_lane_mismatch();
  int          err_start;
  int          edges;
  logic [15:0] cnt_start;
  logic [15:0] cnt_delta;
  err_start     = error_count;
  cnt_start     = rx_upstream_debug_status[31:16];
  corrupt_lane2 = 1'b1;
  repeat (7) @(negedge clk_wr);
  corrupt_lane2 = 1'b0;
  @(negedge clk_wr);
  cnt_delta = rx_upstream_debug_status[31:16] - cnt_start;
  if (cnt_delta !== 16'd7) report_mismatch("mismatch count delta", 160'(7), 160'(cnt_delta));
  dstrm       = random_word();
  dstrm.valid = 1'b1;
  repeat (3) @(negedge clk_wr);
  if (ustrm.valid !== 1'b1) report_mismatch("ustrm.valid", 160'(1), 160'(ustrm.valid));
  rx_online = 1'b0;
  // Delayed online drops on the first edge, ustrm clears on the next
  wait_flag(2, 1'b0, 10, "ustrm clear", edges);
  if (edges != 2) report_mismatch("ustrm clear edge", 160'(2), 160'(edges));
  dstrm = '0;
  finish_test("lane_mismatch", err_start);
endtask

`endif

/* bench/tb_lpif_link.sv */
//////////////////////////////////////////////////
// Testbench top for the LPIF link
// Clock, reset and DUT with PHY loopback
// Lane 2 strobe corruption control
// Xorshift source, waits and error reporting
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_lpif_link;

  import lpif_link_pkg::*;

  logic         clk_wr;
  logic         rst_n;
  logic         tx_online;
  logic         rx_online;
  delay_t       delay_x_value;
  delay_t       delay_xz_value;
  delay_t       delay_yz_value;
  lpif_stream_t dstrm;
  lpif_stream_t ustrm;
  phy_bus_t     tx_phy;
  phy_bus_t     rx_phy;
  logic [31:0]  tx_downstream_debug_status;
  logic [31:0]  rx_upstream_debug_status;
  logic         corrupt_lane2;
  logic [31:0]  rng_state;
  int           error_count;
  int           test_count;

  lpif_link_top DUT (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_xz_value             (delay_xz_value),
    .delay_yz_value             (delay_yz_value),
    .dstrm                      (dstrm),
    .ustrm                      (ustrm),
    .tx_phy                     (tx_phy),
    .rx_phy                     (rx_phy),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

  // Loopback, lane 2 strobe optionally flipped
  always_comb begin
    rx_phy             = tx_phy;
    rx_phy[2][STB_BIT] = tx_phy[2][STB_BIT] ^ corrupt_lane2;
  end

  initial begin
    clk_wr = 1'b0;
    forever #50 clk_wr = ~clk_wr;
  end

  //////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Random stream word, valid set about three times in four
  function automatic lpif_stream_t random_word();
    lpif_stream_t w;
    logic [31:0]  r;
    r           = next_rand();
    w.state     = r[3:0];
    w.protid    = r[5:4];
    w.dvalid    = r[6];
    w.crc       = r[23:8];
    w.crc_valid = r[24];
    w.valid     = r[25] | r[26];
    w.data      = {next_rand(), next_rand()};
    return w;
  endfunction

  function automatic logic probe_flag(input int sel);
    case (sel)
      0:       return tx_phy[0][STB_BIT];
      1:       return ustrm.valid;
      default: return |ustrm;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [159:0] exp,
                                 input logic [159:0] act);
    $display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
    error_count++;
  endtask

  // Falling edges until the flag reaches the level, or a timeout
  task automatic wait_flag(input int sel, input logic level, input int limit,
                           input string name, output int edges);
    edges = 0;
    while (edges < limit) begin
      @(negedge clk_wr);
      edges++;
      if (probe_flag(sel) === level) break;
    end
    if (probe_flag(sel) !== level) begin
      $display("Timeout at %0t ns: %s did not reach %0b within %0d cycles",
               $time, name, level, limit);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    test_count++;
    $display("test %s finished with %0d errors", name, error_count - err_start);
  endtask

  `include "tb_lpif_tests.svh"

  //////////////////////////////////////////////////
  // Test sequence

  initial begin
    rng_state      = 32'hff6d_01d2;
    error_count    = 0;
    test_count     = 0;
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_x_value  = '0;
    delay_xz_value = '0;
    delay_yz_value = '0;
    dstrm          = '0;
    corrupt_lane2  = 1'b0;
    repeat (3) @(posedge clk_wr);
    @(negedge clk_wr);
    rst_n = 1'b1;

    test_reset_state();
    test_online_delay();
    test_loopback();
    test_marker_strobe();
    test_status_counters();
    test_lane_mismatch();

    $display("tests run %0d, errors %0d", test_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/ll_auto_sync.sv */
//////////////////////////////////////////////////
// Auto sync for the LPIF link
// TX and RX online delay counters
// Persistent strobe and alternating marker
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ll_auto_sync (
  input  logic                  clk_wr,
  input  logic                  rst_n,
  input  logic                  tx_online,
  input  logic                  rx_online,
  input  lpif_link_pkg::delay_t delay_x_value,
  input  lpif_link_pkg::delay_t delay_xz_value,
  input  lpif_link_pkg::delay_t delay_yz_value,
  output logic                  tx_online_delay,
  output logic                  rx_online_delay,
  output logic                  tx_auto_stb_userbit,
  output logic                  tx_auto_mrk_userbit
);

  import lpif_link_pkg::*;

  // Index 0 is TX, index 1 is RX
  logic [1:0]               online_in;
  logic [1:0]               online_q;
  // One bit wider than delay_t so the RX sum cannot wrap
  logic [$bits(delay_t):0]  wait_target [2];
  logic                     mrk_q;

  assign online_in      = {rx_online, tx_online};
  assign wait_target[0] = {1'b0, delay_xz_value};
  assign wait_target[1] = {1'b0, delay_x_value} + {1'b0, delay_yz_value};

  //////////////////////////////////////////////////
  // Online delay per direction

  for (genvar i = 0; i < 2; i++) begin : g_dir
    logic [$bits(delay_t):0] wait_cnt;
    logic                    on_q;

    // Counter stops at the target, then the delayed online goes high
    always_ff @(posedge clk_wr or negedge rst_n) begin
      if (!rst_n) begin
        wait_cnt <= '0;
        on_q     <= 1'b0;
      end else if (!online_in[i]) begin
        wait_cnt <= '0;
        on_q     <= 1'b0;
      end else if (wait_cnt >= wait_target[i]) begin
        on_q     <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end

    assign online_q[i] = on_q;
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  //////////////////////////////////////////////////
  // Strobe and marker

  // Phase flop, low on the first online cycle
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      mrk_q <= 1'b0;
    end else if (!tx_online_delay) begin
      mrk_q <= 1'b0;
    end else begin
      mrk_q <= ~mrk_q;
    end
  end

  // Strobe held for as long as TX is online
  assign tx_auto_stb_userbit = tx_online_delay;
  assign tx_auto_mrk_userbit = tx_online_delay & ~mrk_q;

endmodule

`default_nettype wire

/* hdl/lpif_link_pkg.sv */
//////////////////////////////////////////////////
// Shared definitions for the LPIF link
// Lane geometry and user data width
// User stream struct and the flit union
// PHY bus and delay types
//////////////////////////////////////////////////

`default_nettype none

package lpif_link_pkg;

  //////////////////////////////////////////////////
  // Lane geometry

  localparam int NUM_LANES    = 4;
  localparam int LANE_WIDTH   = 40;
  // Lane width minus strobe and marker
  localparam int LANE_PAYLOAD = 38;
  localparam int STB_BIT      = 38;
  localparam int MRK_BIT      = 39;

  localparam int DATA_WIDTH   = 64;

  //////////////////////////////////////////////////
  // User stream

  typedef struct packed {
    logic [3:0]            state;
    logic [1:0]            protid;
    logic [DATA_WIDTH-1:0] data;
    logic                  dvalid;
    logic [15:0]           crc;
    logic                  crc_valid;
    logic                  valid;
  } lpif_stream_t;

  // Payload bits carried by all lanes together
  localparam int FLIT_WIDTH = NUM_LANES * LANE_PAYLOAD;
  localparam int FLIT_PAD   = FLIT_WIDTH - $bits(lpif_stream_t);

  typedef struct packed {
    logic [FLIT_PAD-1:0] pad;
    lpif_stream_t        strm;
  } lpif_flit_fields_t;

  // Same flit seen as stream fields or as lane payloads, lane 0 lowest
  typedef union packed {
    lpif_flit_fields_t                       fields;
    logic [NUM_LANES-1:0][LANE_PAYLOAD-1:0]  lanes;
  } lpif_flit_u;

  //////////////////////////////////////////////////
  // PHY side and configuration

  typedef logic [NUM_LANES-1:0][LANE_WIDTH-1:0] phy_bus_t;

  // Word alignment delay in clock edges
  typedef logic [7:0] delay_t;

endpackage

`default_nettype wire

/* hdl/lpif_link_top.sv */
//////////////////////////////////////////////////
// LPIF link top level
// Auto sync, TX stripe and RX unstripe
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module lpif_link_top (
  input  logic                        clk_wr,
  input  logic                        rst_n,

  // Link control
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  lpif_link_pkg::delay_t       delay_x_value,
  input  lpif_link_pkg::delay_t       delay_xz_value,
  input  lpif_link_pkg::delay_t       delay_yz_value,

  // User streams
  input  lpif_link_pkg::lpif_stream_t dstrm,
  output lpif_link_pkg::lpif_stream_t ustrm,

  // PHY lanes
  output lpif_link_pkg::phy_bus_t     tx_phy,
  input  lpif_link_pkg::phy_bus_t     rx_phy,

  // Debug status
  output logic [31:0]                 tx_downstream_debug_status,
  output logic [31:0]                 rx_upstream_debug_status
);

  logic tx_online_delay;
  logic rx_online_delay;
  logic tx_auto_stb_userbit;
  logic tx_auto_mrk_userbit;

  //////////////////////////////////////////////////
  // Auto sync

  ll_auto_sync u_auto_sync (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_xz_value      (delay_xz_value),
    .delay_yz_value      (delay_yz_value),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  //////////////////////////////////////////////////
  // Data path

  lpif_tx_stripe u_tx_stripe (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .dstrm                      (dstrm),
    .tx_online_delay            (tx_online_delay),
    .tx_auto_stb_userbit        (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit        (tx_auto_mrk_userbit),
    .tx_phy                     (tx_phy),
    .tx_downstream_debug_status (tx_downstream_debug_status)
  );

  lpif_rx_unstripe u_rx_unstripe (
    .clk_wr                   (clk_wr),
    .rst_n                    (rst_n),
    .rx_phy                   (rx_phy),
    .rx_online_delay          (rx_online_delay),
    .ustrm                    (ustrm),
    .rx_upstream_debug_status (rx_upstream_debug_status)
  );

endmodule

`default_nettype wire

/* hdl/lpif_rx_unstripe.sv */
//////////////////////////////////////////////////
// RX unstriping of the upstream stream
// Lane gather and upstream register
// Lane agreement check
// Received word and mismatch counters
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module lpif_rx_unstripe (
  input  logic                        clk_wr,
  input  logic                        rst_n,
  input  lpif_link_pkg::phy_bus_t     rx_phy,
  input  logic                        rx_online_delay,
  output lpif_link_pkg::lpif_stream_t ustrm,
  output logic [31:0]                 rx_upstream_debug_status
);

  import lpif_link_pkg::*;

  lpif_flit_u           rx_flit;
  logic [NUM_LANES-1:1] lane_mismatch;
  logic                 rx_live;
  logic                 mismatch_seen;
  logic [15:0]          rx_word_cnt;
  logic [15:0]          rx_err_cnt;

  //////////////////////////////////////////////////
  // Lane gather

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      rx_flit.lanes[i] = rx_phy[i][LANE_PAYLOAD-1:0];
    end
    // Lane 0 is the reference for strobe and marker
    for (int i = 1; i < NUM_LANES; i++) begin
      lane_mismatch[i] = (rx_phy[i][STB_BIT] != rx_phy[0][STB_BIT]) ||
                         (rx_phy[i][MRK_BIT] != rx_phy[0][MRK_BIT]);
    end
  end

  assign rx_live       = rx_online_delay & rx_phy[0][STB_BIT];
  assign mismatch_seen = rx_online_delay & (|lane_mismatch);

  // Upstream word, zero unless the lanes are live
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      ustrm <= '0;
    end else if (rx_live) begin
      ustrm <= rx_flit.fields.strm;
    end else begin
      ustrm <= '0;
    end
  end

  //////////////////////////////////////////////////
  // Debug status

  // Received valid words, wraps
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_word_cnt <= '0;
    end else if (rx_live && rx_flit.fields.strm.valid) begin
      rx_word_cnt <= rx_word_cnt + 16'd1;
    end
  end

  // Mismatch cycles, saturates at all ones
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_err_cnt <= '0;
    end else if (mismatch_seen && (rx_err_cnt != 16'hffff)) begin
      rx_err_cnt <= rx_err_cnt + 16'd1;
    end
  end

  assign rx_upstream_debug_status = {rx_err_cnt, rx_word_cnt};

endmodule

`default_nettype wire

/* hdl/lpif_tx_stripe.sv */
//////////////////////////////////////////////////
// TX striping of the downstream stream
// Flit packing onto the PHY lanes
// Downstream word counter
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module lpif_tx_stripe (
  input  logic                        clk_wr,
  input  logic                        rst_n,
  input  lpif_link_pkg::lpif_stream_t dstrm,
  input  logic                        tx_online_delay,
  input  logic                        tx_auto_stb_userbit,
  input  logic                        tx_auto_mrk_userbit,
  output lpif_link_pkg::phy_bus_t     tx_phy,
  output logic [31:0]                 tx_downstream_debug_status
);

  import lpif_link_pkg::*;

  lpif_flit_u tx_flit;
  phy_bus_t   tx_phy_nxt;

  //////////////////////////////////////////////////
  // Lane packing

  always_comb begin
    tx_flit             = '0;
    tx_flit.fields.strm = dstrm;
    for (int i = 0; i < NUM_LANES; i++) begin
      tx_phy_nxt[i][LANE_PAYLOAD-1:0] = tx_flit.lanes[i];
      // Every lane carries the same strobe and marker
      tx_phy_nxt[i][STB_BIT]          = tx_auto_stb_userbit;
      tx_phy_nxt[i][MRK_BIT]          = tx_auto_mrk_userbit;
    end
  end

  // Lanes stay quiet until the link is aligned
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else if (!tx_online_delay) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_phy_nxt;
    end
  end

  //////////////////////////////////////////////////
  // Debug status

  // Valid words sent while online, wraps
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_downstream_debug_status <= '0;
    end else if (tx_online_delay && dstrm.valid) begin
      tx_downstream_debug_status <= tx_downstream_debug_status + 32'd1;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LPIF link testbench with Verilator
# The log is searched for the failure line at the end

cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timescale 1ns/1ns --top-module tb_lpif_link -f sources.f \
  -o tb_lpif_link > "$log" 2>&1 \
  && ./obj_dir/tb_lpif_link >> "$log" 2>&1 \
  || { echo "Build or simulation error, see $log"; exit 1; }

if grep -q "Something failed" "$log"; then
  echo "Simulation reported errors, see $log"
  exit 1
fi
echo "Simulation passed"
exit 0

/* sources.f */
+incdir+bench
hdl/lpif_link_pkg.sv
hdl/ll_auto_sync.sv
hdl/lpif_tx_stripe.sv
hdl/lpif_rx_unstripe.sv
hdl/lpif_link_top.sv
bench/tb_lpif_link.sv
